/* verilog/wb_cfg_pkg.sv */
// Data-path widths, word types and start address shared by the write-back stage RTL
package wb_cfg_pkg;

  // Data and address width of the core
  localparam int XLEN = 32;

  // Bits per byte and bytes per word
  localparam int BYTE_LEN = 8;
  localparam int NUM_BYTES = XLEN / BYTE_LEN;

  // Width of the byte offset inside a word
  localparam int OFFSET_W = $clog2(NUM_BYTES);

  // Register file index width, 32 registers
  localparam int RF_ADDR_W = 5;

  // Step of the sequential PC
  localparam int INSTR_BYTES = 4;

  // Data and address word
  typedef logic [XLEN-1:0] xlen_t;

  // PC presented while the core is held in reset
  localparam xlen_t START_ADDR = 32'h0000_0000;

  // Byte enables, byte offset and register index
  typedef logic [NUM_BYTES-1:0] be_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

endpackage

/* verilog/wb_isa_pkg.sv */
// Encodings of the PC, data memory and register write control fields from the decoder
package wb_isa_pkg;

  // Bit of the memory code that marks a store
  localparam int MEM_STORE_BIT = 4;

  // Next-PC selection
  typedef enum logic [1:0] {
    // Sequential, pc + 4
    PC_INC  = 2'b00,
    // Absolute jump to the ALU value (JALR)
    PC_SET  = 2'b01,
    // PC-relative jump by the ALU value (JAL)
    PC_ADD  = 2'b10,
    // Branch by operand 3 when ALU bit 0 is set
    PC_COND = 2'b11
  } pc_ctrl_e;

  // Data memory operation
  // Bit 3 marks a zero-extending load, bits 1:0 give the access size
  typedef enum logic [4:0] {
    MEM_IDLE = 5'b00000,
    // Loads
    MEM_RB   = 5'b00001,
    MEM_RBU  = 5'b01001,
    MEM_RH   = 5'b00010,
    MEM_RHU  = 5'b01010,
    MEM_RW   = 5'b00011,
    // Stores
    MEM_WB   = 5'b10001,
    MEM_WH   = 5'b10010,
    MEM_WW   = 5'b10011
  } mem_ctrl_e;

  // Source of the register file write
  typedef enum logic [2:0] {
    // No register write
    GPR_NONE = 3'b000,
    // Formatted load data
    GPR_MEM  = 3'b100,
    // ALU result
    GPR_ALU  = 3'b101,
    // Link address, pc + 4
    GPR_PC   = 3'b110,
    // Operand 3, used for CSR reads
    GPR_OP3  = 3'b111
  } gpr_ctrl_e;

endpackage

/* verilog/lsu_access.sv */
// Data memory access unit that issues requests, formats stores and extracts load results
`timescale 1ns/1ps

module lsu_access (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  wb_isa_pkg::mem_ctrl_e mem_ctrl_i,
  input  wb_cfg_pkg::xlen_t     exe_out_i,
  input  wb_cfg_pkg::xlen_t     op3_i,
  input  logic                  rvalid_i,
  input  wb_cfg_pkg::xlen_t     rdata_i,
  output logic                  req_o,
  output wb_cfg_pkg::xlen_t     addr_o,
  output logic                  we_o,
  output wb_cfg_pkg::xlen_t     wdata_o,
  output wb_cfg_pkg::be_t       be_o,
  output logic                  mem_active_o,
  output logic                  mem_done_o,
  output wb_cfg_pkg::xlen_t     load_value_o
);

  localparam int XLEN = wb_cfg_pkg::XLEN;
  localparam int BYTE_LEN = wb_cfg_pkg::BYTE_LEN;
  localparam int OFFSET_W = wb_cfg_pkg::OFFSET_W;

  logic                mem_active;
  logic                is_store;
  logic                req;
  logic                done_q;
  wb_cfg_pkg::offset_t offset;
  wb_cfg_pkg::offset_t offset_q;
  wb_cfg_pkg::xlen_t   byte_data;
  wb_cfg_pkg::xlen_t   half_data;
  wb_cfg_pkg::xlen_t   rdata_shifted;

  // Any non-idle code is a memory instruction
  assign mem_active = (mem_ctrl_i != wb_isa_pkg::MEM_IDLE);
  assign is_store   = mem_ctrl_i[wb_isa_pkg::MEM_STORE_BIT];

  // Request stays up until the completion cycle
  assign req = mem_active && !done_q;

  // Byte offset of the effective address
  assign offset = exe_out_i[OFFSET_W-1:0];

  // Word-aligned address toward memory
  assign addr_o = {exe_out_i[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign req_o  = req;
  assign we_o   = is_store;

  // Store payloads placed in the low lanes before the offset shift
  assign byte_data = wb_cfg_pkg::xlen_t'(op3_i[BYTE_LEN-1:0]);
  assign half_data = wb_cfg_pkg::xlen_t'(op3_i[2*BYTE_LEN-1:0]);

  // Store lane placement and byte enables
  always_comb begin
    wdata_o = '0;
    be_o    = '1;
    case (mem_ctrl_i)
      wb_isa_pkg::MEM_WB: begin
        wdata_o = byte_data << (offset * BYTE_LEN);
        be_o    = wb_cfg_pkg::be_t'(1) << offset;
      end
      wb_isa_pkg::MEM_WH: begin
        wdata_o = half_data << (offset * BYTE_LEN);
        be_o    = wb_cfg_pkg::be_t'(3) << offset;
      end
      wb_isa_pkg::MEM_WW: begin
        wdata_o = op3_i;
      end
      // Loads read with every lane enabled
      default: begin
        wdata_o = '0;
      end
    endcase
  end

  // Completion pulse one cycle after the accepted response
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= req && rvalid_i;
    end
  end

  // Offset saved while a read is outstanding
  // Used in the completion cycle when the address may already have moved
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      offset_q <= '0;
    end else if (req && !is_store) begin
      offset_q <= offset;
    end
  end

  // Addressed lane moved down to bit 0
  assign rdata_shifted = rdata_i >> (offset_q * BYTE_LEN);

  // Size selection and extension of the load result
  always_comb begin
    case (mem_ctrl_i)
      wb_isa_pkg::MEM_RB: begin
        load_value_o = {{(XLEN-BYTE_LEN){rdata_shifted[BYTE_LEN-1]}},
                        rdata_shifted[BYTE_LEN-1:0]};
      end
      wb_isa_pkg::MEM_RBU: begin
        load_value_o = {{(XLEN-BYTE_LEN){1'b0}}, rdata_shifted[BYTE_LEN-1:0]};
      end
      wb_isa_pkg::MEM_RH: begin
        load_value_o = {{(XLEN-2*BYTE_LEN){rdata_shifted[2*BYTE_LEN-1]}},
                        rdata_shifted[2*BYTE_LEN-1:0]};
      end
      wb_isa_pkg::MEM_RHU: begin
        load_value_o = {{(XLEN-2*BYTE_LEN){1'b0}}, rdata_shifted[2*BYTE_LEN-1:0]};
      end
      // Word loads pass through unchanged
      default: begin
        load_value_o = rdata_i;
      end
    endcase
  end

  assign mem_active_o = mem_active;
  assign mem_done_o   = done_q;

  // Under back-pressure the request stays up with the same code
  a_req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_o && !rvalid_i |=> req_o && $stable(mem_ctrl_i));

  // Completion is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
    done_q |=> !done_q);

  // Enables cover one, two or four adjacent lanes
  a_be_shape: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_o |-> be_o inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                           4'b0011, 4'b0110, 4'b1100, 4'b1111});

endmodule

/* verilog/branch_target.sv */
// Branch target unit: sequential PC, jump or branch target and the taken decision
`timescale 1ns/1ps

module branch_target (
  input  wb_cfg_pkg::xlen_t    pc_i,
  input  wb_cfg_pkg::xlen_t    exe_out_i,
  input  wb_cfg_pkg::xlen_t    op3_i,
  input  wb_isa_pkg::pc_ctrl_e pc_ctrl_i,
  output wb_cfg_pkg::xlen_t    pc_plus4_o,
  output wb_cfg_pkg::xlen_t    target_o,
  output logic                 take_o
);

  localparam int XLEN = wb_cfg_pkg::XLEN;

  // Next sequential instruction, also the link address
  assign pc_plus4_o = pc_i + wb_cfg_pkg::xlen_t'(wb_cfg_pkg::INSTR_BYTES);

  // Target and decision per PC control code
  always_comb begin
    case (pc_ctrl_i)
      // JALR, bit 0 of the computed address is dropped
      wb_isa_pkg::PC_SET: begin
        target_o = {exe_out_i[XLEN-1:1], 1'b0};
        take_o   = 1'b1;
      end
      // JAL, offset already in the ALU result
      wb_isa_pkg::PC_ADD: begin
        target_o = pc_i + exe_out_i;
        take_o   = 1'b1;
      end
      // Branch offset in operand 3, condition in ALU bit 0
      wb_isa_pkg::PC_COND: begin
        target_o = pc_i + op3_i;
        take_o   = exe_out_i[0];
      end
      default: begin
        target_o = pc_plus4_o;
        take_o   = 1'b0;
      end
    endcase
  end

endmodule

/* verilog/wb_commit.sv */
// Commit unit choosing the register write and the next PC from memory and branch results
`timescale 1ns/1ps

module wb_commit (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  decode_valid_i,
  input  wb_isa_pkg::gpr_ctrl_e gpr_ctrl_i,
  input  wb_cfg_pkg::xlen_t     exe_out_i,
  input  wb_cfg_pkg::xlen_t     op3_i,
  input  wb_cfg_pkg::xlen_t     pc_i,
  input  wb_cfg_pkg::xlen_t     pc_plus4_i,
  input  wb_cfg_pkg::xlen_t     target_i,
  input  logic                  take_i,
  input  logic                  mem_active_i,
  input  logic                  mem_done_i,
  input  wb_cfg_pkg::xlen_t     load_value_i,
  output logic                  rd_valid_o,
  output wb_cfg_pkg::xlen_t     rd_val_o,
  output wb_cfg_pkg::xlen_t     pc_next_o
);

  // Register write source and its valid
  always_comb begin
    case (gpr_ctrl_i)
      wb_isa_pkg::GPR_ALU: begin
        rd_val_o   = exe_out_i;
        rd_valid_o = decode_valid_i;
      end
      // Link address for JAL and JALR
      wb_isa_pkg::GPR_PC: begin
        rd_val_o   = pc_plus4_i;
        rd_valid_o = decode_valid_i;
      end
      wb_isa_pkg::GPR_OP3: begin
        rd_val_o   = op3_i;
        rd_valid_o = decode_valid_i;
      end
      // Load data only counts in the completion cycle
      wb_isa_pkg::GPR_MEM: begin
        rd_val_o   = load_value_i;
        rd_valid_o = mem_done_i;
      end
      // No write for stores, branches and idle slots
      default: begin
        rd_val_o   = '0;
        rd_valid_o = 1'b0;
      end
    endcase
  end

  // Next PC with reset first, then hold, memory stall and control flow
  always_comb begin
    if (!rstn_i) begin
      pc_next_o = wb_cfg_pkg::START_ADDR;
    end else if (!decode_valid_i) begin
      // Bubble keeps the current PC
      pc_next_o = pc_i;
    end else if (mem_active_i) begin
      // Stall until the access completes
      if (mem_done_i) begin
        pc_next_o = pc_plus4_i;
      end else begin
        pc_next_o = pc_i;
      end
    end else if (take_i) begin
      pc_next_o = target_i;
    end else begin
      pc_next_o = pc_plus4_i;
    end
  end

  // Load data is written only while the load is still presented
  a_load_write_presented: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rd_valid_o && gpr_ctrl_i == wb_isa_pkg::GPR_MEM |-> mem_active_i);

endmodule

/* verilog/writeback_stage.sv */
// Write-back stage top level linking the access, branch and commit units to core and memory
`timescale 1ns/1ps

module writeback_stage (
  input  logic                     clk_i,
  input  logic                     rstn_i,
  // Core side
  input  wb_cfg_pkg::xlen_t        exe_out_i,
  input  wb_cfg_pkg::xlen_t        op3_i,
  input  logic                     decode_valid_i,
  input  wb_cfg_pkg::rf_addr_t     rd_i,
  input  wb_cfg_pkg::xlen_t        pc_i,
  input  wb_isa_pkg::pc_ctrl_e     pc_ctrl_i,
  input  wb_isa_pkg::mem_ctrl_e    mem_ctrl_i,
  input  wb_isa_pkg::gpr_ctrl_e    gpr_ctrl_i,
  // Register file and PC
  output wb_cfg_pkg::rf_addr_t     rd_o,
  output logic                     rd_valid_o,
  output wb_cfg_pkg::xlen_t        rd_val_o,
  output wb_cfg_pkg::xlen_t        pc_next_o,
  // Data memory
  output logic                     req_o,
  output wb_cfg_pkg::xlen_t        addr_o,
  output logic                     we_o,
  output wb_cfg_pkg::xlen_t        wdata_o,
  output wb_cfg_pkg::be_t          be_o,
  input  logic                     rvalid_i,
  input  wb_cfg_pkg::xlen_t        rdata_i
);

  // Access unit status toward commit
  logic              mem_active;
  logic              mem_done;
  wb_cfg_pkg::xlen_t load_value;

  // Branch unit results toward commit
  wb_cfg_pkg::xlen_t pc_plus4;
  wb_cfg_pkg::xlen_t target;
  logic              take;

  // Destination index goes straight to the register file
  assign rd_o = rd_i;

  lsu_access i_lsu (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .mem_ctrl_i  (mem_ctrl_i),
    .exe_out_i   (exe_out_i),
    .op3_i       (op3_i),
    .rvalid_i    (rvalid_i),
    .rdata_i     (rdata_i),
    .req_o       (req_o),
    .addr_o      (addr_o),
    .we_o        (we_o),
    .wdata_o     (wdata_o),
    .be_o        (be_o),
    .mem_active_o(mem_active),
    .mem_done_o  (mem_done),
    .load_value_o(load_value)
  );

  branch_target i_branch (
    .pc_i      (pc_i),
    .exe_out_i (exe_out_i),
    .op3_i     (op3_i),
    .pc_ctrl_i (pc_ctrl_i),
    .pc_plus4_o(pc_plus4),
    .target_o  (target),
    .take_o    (take)
  );

  wb_commit i_commit (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .decode_valid_i(decode_valid_i),
    .gpr_ctrl_i    (gpr_ctrl_i),
    .exe_out_i     (exe_out_i),
    .op3_i         (op3_i),
    .pc_i          (pc_i),
    .pc_plus4_i    (pc_plus4),
    .target_i      (target),
    .take_i        (take),
    .mem_active_i  (mem_active),
    .mem_done_i    (mem_done),
    .load_value_i  (load_value),
    .rd_valid_o    (rd_valid_o),
    .rd_val_o      (rd_val_o),
    .pc_next_o     (pc_next_o)
  );

endmodule

/* tests/tb_tasks.svh */
// Directed test tasks, reference rules and random source included by the write-back testbench
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

// Compares one output and reports hex values on a mismatch
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    value_errors++;
    $display("Error: %s is %h, expected %h", name, got, exp);
  end
endtask

// Expected next PC of a completing non-memory instruction
function automatic logic [31:0] next_pc_ref(input wb_isa_pkg::pc_ctrl_e pcc,
    input logic [31:0] pc, input logic [31:0] exe, input logic [31:0] op3);
  case (pcc)
    wb_isa_pkg::PC_SET:  return exe & ~32'h1;
    wb_isa_pkg::PC_ADD:  return pc + exe;
    wb_isa_pkg::PC_COND: return exe[0] ? pc + op3 : pc + 32'd4;
    default:             return pc + 32'd4;
  endcase
endfunction

// Payload byte k of a store lands in lane offset + k
task automatic store_ref(input wb_isa_pkg::mem_ctrl_e code, input logic [31:0] data,
    input logic [1:0] offset, output logic [31:0] wdata, output logic [3:0] be);
  int size;
  size  = (code == wb_isa_pkg::MEM_WB) ? 1 : (code == wb_isa_pkg::MEM_WH) ? 2 : 4;
  wdata = '0;
  be    = '0;
  for (int k = 0; k < size; k++) begin
    wdata[(offset + k) * 8 +: 8] = data[k * 8 +: 8];
    be[offset + k] = 1'b1;
  end
endtask

// Load result taken from the offset upward and then extended
function automatic logic [31:0] load_ref(input wb_isa_pkg::mem_ctrl_e code,
    input logic [31:0] word, input logic [1:0] offset);
  int          size;
  logic        sext;
  logic [31:0] value;
  sext = (code == wb_isa_pkg::MEM_RB) || (code == wb_isa_pkg::MEM_RH);
  if (code == wb_isa_pkg::MEM_RB || code == wb_isa_pkg::MEM_RBU) begin
    size = 1;
  end else if (code == wb_isa_pkg::MEM_RH || code == wb_isa_pkg::MEM_RHU) begin
    size = 2;
  end else begin
    size = 4;
  end
  value = '0;
  for (int k = 0; k < size; k++) begin
    value[k * 8 +: 8] = word[(offset + k) * 8 +: 8];
  end
  if (sext && value[size * 8 - 1]) begin
    for (int b = size * 8; b < 32; b++) begin
      value[b] = 1'b1;
    end
  end
  return value;
endfunction

// Presents one instruction on the falling edge and returns once outputs settle
task automatic drive_instr(input logic valid, input logic [31:0] pc, input logic [31:0] exe,
    input logic [31:0] op3, input logic [4:0] rd, input wb_isa_pkg::pc_ctrl_e pcc,
    input wb_isa_pkg::mem_ctrl_e memc, input wb_isa_pkg::gpr_ctrl_e gprc);
  @(negedge clk_i);
  decode_valid_i = valid;
  pc_i           = pc;
  exe_out_i      = exe;
  op3_i          = op3;
  rd_i           = rd;
  pc_ctrl_i      = pcc;
  mem_ctrl_i     = memc;
  gpr_ctrl_i     = gprc;
  #1;
endtask

// Bubble cycle with the PC held and no register write
task automatic hold_idle(input logic [31:0] pc);
  drive_instr(1'b0, pc, '0, '0, '0, wb_isa_pkg::PC_INC, wb_isa_pkg::MEM_IDLE,
              wb_isa_pkg::GPR_NONE);
  check_value("rd_valid_o", rd_valid_o, 32'd0);
  check_value("pc_next_o", pc_next_o, pc);
endtask

// Start address while in reset and hold with no valid instruction afterwards
task automatic run_reset_idle();
  repeat (RESET_CYCLES - 1) begin
    @(negedge clk_i);
    #1;
    check_value("pc_next_o", pc_next_o, wb_cfg_pkg::START_ADDR);
    check_value("rd_valid_o", rd_valid_o, 32'd0);
  end
  @(negedge clk_i);
  rstn_i = 1'b1;
  #1;
  check_value("pc_next_o", pc_next_o, pc_i);
  check_value("rd_valid_o", rd_valid_o, 32'd0);
  hold_idle(32'h0000_0180);
endtask

// ALU, operand 3 and link sources with their valid
task automatic check_reg_source(input wb_isa_pkg::gpr_ctrl_e gprc, input logic valid);
  logic [31:0] pc;
  logic [31:0] exe;
  logic [31:0] op3;
  logic [31:0] exp;
  pc  = 32'h0000_0200;
  exe = 32'h1234_5678;
  op3 = 32'h9ABC_DEF0;
  if (gprc == wb_isa_pkg::GPR_ALU) begin
    exp = exe;
  end else if (gprc == wb_isa_pkg::GPR_OP3) begin
    exp = op3;
  end else begin
    exp = pc + 32'd4;
  end
  drive_instr(valid, pc, exe, op3, 5'd7, wb_isa_pkg::PC_INC, wb_isa_pkg::MEM_IDLE, gprc);
  check_value("rd_o", 32'(rd_o), 32'd7);
  check_value("rd_valid_o", 32'(rd_valid_o), 32'(valid));
  check_value("rd_val_o", rd_val_o, exp);
  check_value("pc_next_o", pc_next_o, valid ? pc + 32'd4 : pc);
endtask

// Jumps write the link address and branches write nothing
task automatic check_control_flow(input wb_isa_pkg::pc_ctrl_e pcc, input logic [31:0] pc,
    input logic [31:0] exe, input logic [31:0] op3);
  wb_isa_pkg::gpr_ctrl_e gprc;
  gprc = (pcc == wb_isa_pkg::PC_COND) ? wb_isa_pkg::GPR_NONE : wb_isa_pkg::GPR_PC;
  drive_instr(1'b1, pc, exe, op3, 5'd1, pcc, wb_isa_pkg::MEM_IDLE, gprc);
  check_value("pc_next_o", pc_next_o, next_pc_ref(pcc, pc, exe, op3));
  check_value("req_o", 32'(req_o), 32'd0);
  if (gprc == wb_isa_pkg::GPR_PC) begin
    check_value("rd_valid_o", 32'(rd_valid_o), 32'd1);
    check_value("rd_val_o", rd_val_o, pc + 32'd4);
  end else begin
    check_value("rd_valid_o", 32'(rd_valid_o), 32'd0);
  end
endtask

// Store held until the response and completed with pc + 4
task automatic run_store(input wb_isa_pkg::mem_ctrl_e code, input logic [1:0] offset);
  logic [31:0] pc;
  logic [31:0] addr;
  logic [31:0] data;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_be;
  int          cycles;
  pc   = 32'h0000_2400 + {28'd0, offset, 2'b00};
  addr = 32'h0001_0040 | {30'd0, offset};
  data = 32'hC3B7_8E5A + {30'd0, offset} * 32'h0101_0101;
  store_ref(code, data, offset, exp_wdata, exp_be);
  drive_instr(1'b1, pc, addr, data, 5'd0, wb_isa_pkg::PC_INC, code, wb_isa_pkg::GPR_NONE);
  check_value("req_o", 32'(req_o), 32'd1);
  cycles = 0;
  while (req_o === 1'b1 && cycles < MAX_WAIT) begin
    check_value("we_o", 32'(we_o), 32'd1);
    check_value("pc_next_o", pc_next_o, pc);
    check_value("addr_o", addr_o, addr & ~32'h3);
    check_value("wdata_o", wdata_o, exp_wdata);
    check_value("be_o", 32'(be_o), 32'(exp_be));
    @(negedge clk_i);
    #1;
    cycles++;
  end
  assert (cycles < MAX_WAIT) else begin
    timeouts++;
    $display("Timeout: store to address %h was never answered", addr);
  end
  // Completion cycle
  check_value("req_o", 32'(req_o), 32'd0);
  check_value("pc_next_o", pc_next_o, pc + 32'd4);
  hold_idle(pc + 32'd4);
endtask

// Load stalls without a write and then writes the extracted value for one cycle
task automatic run_load(input wb_isa_pkg::mem_ctrl_e code, input logic [1:0] offset);
  logic [31:0] pc;
  logic [31:0] addr;
  int          cycles;
  pc   = 32'h0000_3100 + {28'd0, offset, 2'b00};
  addr = 32'h0002_0080 | {30'd0, offset};
  drive_instr(1'b1, pc, addr, '0, 5'd10, wb_isa_pkg::PC_INC, code, wb_isa_pkg::GPR_MEM);
  check_value("req_o", 32'(req_o), 32'd1);
  cycles = 0;
  while (req_o === 1'b1 && cycles < MAX_WAIT) begin
    check_value("rd_valid_o", 32'(rd_valid_o), 32'd0);
    check_value("pc_next_o", pc_next_o, pc);
    check_value("we_o", 32'(we_o), 32'd0);
    check_value("be_o", 32'(be_o), 32'hF);
    check_value("addr_o", addr_o, addr & ~32'h3);
    @(negedge clk_i);
    #1;
    cycles++;
  end
  assert (cycles < MAX_WAIT) else begin
    timeouts++;
    $display("Timeout: load from address %h was never answered", addr);
  end
  // Completion cycle with the read word still held by the memory model
  check_value("rd_valid_o", 32'(rd_valid_o), 32'd1);
  check_value("rd_val_o", rd_val_o, load_ref(code, rdata_i, offset));
  check_value("pc_next_o", pc_next_o, pc + 32'd4);
  // Load data source kept selected, the write must not repeat
  drive_instr(1'b0, pc + 32'd4, '0, '0, 5'd10, wb_isa_pkg::PC_INC, wb_isa_pkg::MEM_IDLE,
              wb_isa_pkg::GPR_MEM);
  check_value("rd_valid_o", 32'(rd_valid_o), 32'd0);
  check_value("pc_next_o", pc_next_o, pc + 32'd4);
endtask

`endif

/* tests/tb_writeback.sv */
// Testbench top for the write-back stage, runs the directed tests against a modelled data memory
`timescale 1ns/1ps

module tb_writeback;

  // Run length in clock cycles
  localparam int RESET_CYCLES = 8;
  localparam int TEST_STEPS = 29;
  localparam int CYCLES_PER_STEP = 5;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_STEPS * CYCLES_PER_STEP + 40;
  // Longest wait for one memory access
  localparam int MAX_WAIT = 8;

  logic                  clk_i;
  logic                  rstn_i;
  wb_cfg_pkg::xlen_t     exe_out_i;
  wb_cfg_pkg::xlen_t     op3_i;
  logic                  decode_valid_i;
  wb_cfg_pkg::rf_addr_t  rd_i;
  wb_cfg_pkg::xlen_t     pc_i;
  wb_isa_pkg::pc_ctrl_e  pc_ctrl_i;
  wb_isa_pkg::mem_ctrl_e mem_ctrl_i;
  wb_isa_pkg::gpr_ctrl_e gpr_ctrl_i;
  logic                  rvalid_i;
  wb_cfg_pkg::xlen_t     rdata_i;
  wb_cfg_pkg::rf_addr_t  rd_o;
  logic                  rd_valid_o;
  wb_cfg_pkg::xlen_t     rd_val_o;
  wb_cfg_pkg::xlen_t     pc_next_o;
  logic                  req_o;
  wb_cfg_pkg::xlen_t     addr_o;
  logic                  we_o;
  wb_cfg_pkg::xlen_t     wdata_o;
  wb_cfg_pkg::be_t       be_o;

  // Result counters
  int checks;
  int value_errors;
  int timeouts;

  // Memory model state
  logic [31:0] rng_state;
  int          wait_cycles;
  int          resp_latency;
  logic        resp_next;
  logic [31:0] resp_data;

  `include "tb_tasks.svh"

  writeback_stage i_dut (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .exe_out_i     (exe_out_i),
    .op3_i         (op3_i),
    .decode_valid_i(decode_valid_i),
    .rd_i          (rd_i),
    .pc_i          (pc_i),
    .pc_ctrl_i     (pc_ctrl_i),
    .mem_ctrl_i    (mem_ctrl_i),
    .gpr_ctrl_i    (gpr_ctrl_i),
    .rd_o          (rd_o),
    .rd_valid_o    (rd_valid_o),
    .rd_val_o      (rd_val_o),
    .pc_next_o     (pc_next_o),
    .req_o         (req_o),
    .addr_o        (addr_o),
    .we_o          (we_o),
    .wdata_o       (wdata_o),
    .be_o          (be_o),
    .rvalid_i      (rvalid_i),
    .rdata_i       (rdata_i)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  // Memory model decides on the rising edge from the values seen before it
  always @(posedge clk_i) begin
    if (!rstn_i || req_o !== 1'b1 || rvalid_i) begin
      // Nothing pending, or the response is taken at this edge
      wait_cycles = 0;
      resp_next   = 1'b0;
    end else begin
      // A new request draws a latency of one or two cycles
      if (wait_cycles == 0) begin
        rng_state    = xorshift32(rng_state);
        resp_latency = 1 + int'(rng_state[0]);
      end
      wait_cycles = wait_cycles + 1;
      if (wait_cycles >= resp_latency) begin
        rng_state = xorshift32(rng_state);
        resp_data = rng_state;
        resp_next = 1'b1;
      end
    end
  end

  // Response lines change on the falling edge, read data is held after completion
  always @(negedge clk_i) begin
    rvalid_i <= resp_next;
    if (resp_next) begin
      rdata_i <= resp_data;
    end
  end

  // Ends a run that stops making progress
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired: the test sequence did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int off;
    clk_i          = 1'b0;
    rstn_i         = 1'b0;
    exe_out_i      = '0;
    op3_i          = '0;
    decode_valid_i = 1'b0;
    rd_i           = '0;
    pc_i           = 32'h0000_0100;
    pc_ctrl_i      = wb_isa_pkg::PC_INC;
    mem_ctrl_i     = wb_isa_pkg::MEM_IDLE;
    gpr_ctrl_i     = wb_isa_pkg::GPR_NONE;
    rvalid_i       = 1'b0;
    rdata_i        = '0;
    checks         = 0;
    value_errors   = 0;
    timeouts       = 0;
    rng_state      = 32'd18;
    wait_cycles    = 0;
    resp_latency   = 1;
    resp_next      = 1'b0;
    resp_data      = '0;

    run_reset_idle();

    // Register write sources
    check_reg_source(wb_isa_pkg::GPR_ALU, 1'b1);
    check_reg_source(wb_isa_pkg::GPR_OP3, 1'b1);
    check_reg_source(wb_isa_pkg::GPR_PC, 1'b1);
    check_reg_source(wb_isa_pkg::GPR_ALU, 1'b0);

    // Jumps and branches
    check_control_flow(wb_isa_pkg::PC_SET, 32'h0000_0400, 32'h0000_8765, 32'h0);
    check_control_flow(wb_isa_pkg::PC_ADD, 32'h0000_0500, 32'h0000_0120, 32'h0);
    check_control_flow(wb_isa_pkg::PC_COND, 32'h0000_0600, 32'h1, 32'hFFFF_FFF0);
    check_control_flow(wb_isa_pkg::PC_COND, 32'h0000_0700, 32'h0, 32'h0000_0040);

    // Stores at each legal offset
    for (off = 0; off < 4; off++) begin
      run_store(wb_isa_pkg::MEM_WB, off[1:0]);
    end
    for (off = 0; off < 4; off += 2) begin
      run_store(wb_isa_pkg::MEM_WH, off[1:0]);
    end
    run_store(wb_isa_pkg::MEM_WW, 2'd0);

    // Loads at each legal offset
    for (off = 0; off < 4; off++) begin
      run_load(wb_isa_pkg::MEM_RB, off[1:0]);
      run_load(wb_isa_pkg::MEM_RBU, off[1:0]);
    end
    for (off = 0; off < 4; off += 2) begin
      run_load(wb_isa_pkg::MEM_RH, off[1:0]);
      run_load(wb_isa_pkg::MEM_RHU, off[1:0]);
    end
    run_load(wb_isa_pkg::MEM_RW, 2'd0);

    $display("Summary: %0d checks, %0d value errors, %0d timeouts",
             checks, value_errors, timeouts);
    if (value_errors + timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+tests
verilog/wb_cfg_pkg.sv
verilog/wb_isa_pkg.sv
verilog/lsu_access.sv
verilog/branch_target.sv
verilog/wb_commit.sv
verilog/writeback_stage.sv
tests/tb_writeback.sv
